// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fads_tb
FILELIST  ?= fads_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== fads_top.f ====
rtl/fads_pkg.sv
rtl/fads_regs.sv
rtl/fads_us_timer.sv
rtl/droplet_detector.sv
rtl/droplet_classifier.sv
rtl/sort_scheduler.sv
rtl/fads_top.sv
sim/fads_tb.sv

// ==== rtl/droplet_classifier.sv ====
`timescale 1ns/100ps

module droplet_classifier (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fads_pkg::fads_cfg_t         cfg_i,
    input  fads_pkg::droplet_meas_t     meas_i,
    input  logic                        meas_valid_i,
    input  logic [fads_pkg::MEAS_W-1:0] now_us_i,
    input  logic                        sort_busy_i,
    output fads_pkg::droplet_result_t   result_o,
    output logic                        sort_req_o
);
    import fads_pkg::*;

    logic [N_CH-1:0]    int_low;
    logic [N_CH-1:0]    int_pos;
    logic [N_CH-1:0]    int_high;
    logic [N_CH-1:0]    wid_low;
    logic [N_CH-1:0]    wid_pos;
    logic [N_CH-1:0]    wid_high;
    logic               positive;
    logic               negative;
    logic               accepted;
    logic               sort_go;
    logic [CLS_W-1:0]   cls;
    logic [SENSE_W-1:0] s;
    droplet_result_t    result_q;
    logic               sort_req_q;

    // Per-channel bands
    for (genvar c = 0; c < N_CH; c++) begin : g_ch
        chan_meas_t m;
        chan_thr_t  t;
        assign m = meas_i.ch[c];
        assign t = cfg_i.thr[c];
        assign int_low[c]  = (m.peak >= t.int_min) && (m.peak < t.int_low);
        assign int_pos[c]  = (m.peak >= t.int_low) && (m.peak < t.int_high);
        assign int_high[c] = m.peak >= t.int_high;
        assign wid_low[c]  = (m.width >= t.wid_min) && (m.width < t.wid_low);
        assign wid_pos[c]  = (m.width >= t.wid_low) && (m.width < t.wid_high)
                             && (m.width >= t.wid_min);
        assign wid_high[c] = m.width >= t.wid_high;
    end

    assign s        = cfg_i.sense_ch;
    assign positive = &int_pos && &wid_pos;
    assign negative = |(int_low | int_pos | int_high) && |(wid_low | wid_pos | wid_high)
                      && !positive;
    assign accepted = (meas_i.ch[s].width >= cfg_i.thr[s].wid_min)
                      && (meas_i.ch[s].area >= cfg_i.thr[s].area_min)
                      && (positive || negative);
    assign sort_go  = accepted && positive && !sort_busy_i;   // Busy sorter drops the request

    always_comb begin
        cls               = '0;
        cls[CLS_INT_LOW]  = |int_low;
        cls[CLS_INT_POS]  = &int_pos;
        cls[CLS_INT_HIGH] = |int_high;
        cls[CLS_WID_LOW]  = |wid_low;
        cls[CLS_WID_POS]  = &wid_pos;
        cls[CLS_WID_HIGH] = |wid_high;
        cls[CLS_SORTED]   = sort_go;
        cls[CLS_POSITIVE] = positive;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i || cfg_i.soft_reset) begin
            result_q   <= '0;
            sort_req_q <= 1'b0;
        end else begin
            sort_req_q <= meas_valid_i && sort_go;
            if (meas_valid_i && accepted) begin
                result_q.id      <= result_q.id + MEAS_W'(1);
                result_q.meas    <= meas_i;
                result_q.cls     <= cls;
                result_q.time_us <= now_us_i;
            end
        end
    end

    assign result_o   = result_q;
    assign sort_req_o = sort_req_q;

endmodule

// ==== rtl/droplet_detector.sv ====
`timescale 1ns/100ps

module droplet_detector (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  fads_pkg::adc_sample_t                      adc_a_i,
    input  fads_pkg::adc_sample_t                      adc_b_i,
    input  fads_pkg::fads_cfg_t                        cfg_i,
    output fads_pkg::adc_sample_t [fads_pkg::N_CH-1:0] adc_o,
    output fads_pkg::droplet_meas_t                    meas_o,
    output logic                                       meas_valid_o
);
    import fads_pkg::*;

    adc_sample_t [N_CH-1:0] adc_q;
    det_state_e             state_q;
    droplet_meas_t          meas_q;
    logic                   meas_valid_q;
    logic [SENSE_W-1:0]     s;
    logic                   sense_hit;

    // Input registers, both channels sampled together
    always_ff @(posedge clk_i) begin
        adc_q[0] <= adc_a_i;
        adc_q[1] <= adc_b_i;
    end

    assign s         = cfg_i.sense_ch;
    assign sense_hit = $signed(adc_q[s]) >= cfg_i.thr[s].int_min;

    //////////////////////////////////////////////////////////////////////
    // Acquisition FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        meas_valid_q <= 1'b0;
        if (!rstn_i || cfg_i.soft_reset) begin
            state_q <= DET_IDLE;
        end else begin
            case (state_q)
                DET_IDLE: state_q <= DET_WAIT;

                DET_WAIT: begin
                    if (sense_hit) begin
                        // Fresh accumulators; both areas take the first sample
                        for (int c = 0; c < N_CH; c++) begin
                            meas_q.ch[c].peak  <= SIGNAL_MAX_INIT;
                            meas_q.ch[c].width <= '0;
                            meas_q.ch[c].area  <= MEAS_W'($signed(adc_q[c]));
                        end
                        meas_q.ch[s].peak  <= adc_q[s];
                        meas_q.ch[s].width <= MEAS_W'(1);
                        state_q <= DET_ACQUIRE;
                    end
                end

                DET_ACQUIRE: begin
                    for (int c = 0; c < N_CH; c++) begin
                        if ($signed(adc_q[c]) > meas_q.ch[c].peak) begin
                            meas_q.ch[c].peak <= adc_q[c];
                        end
                    end
                    if (sense_hit) begin
                        meas_q.ch[s].width <= meas_q.ch[s].width + MEAS_W'(1);
                        for (int c = 0; c < N_CH; c++) begin
                            meas_q.ch[c].area <= meas_q.ch[c].area + MEAS_W'($signed(adc_q[c]));
                        end
                    end else begin
                        state_q      <= DET_EVAL;   // Falling edge of droplet
                        meas_valid_q <= 1'b1;
                    end
                end

                DET_EVAL: state_q <= DET_WAIT;

                default: state_q <= DET_IDLE;
            endcase
        end
    end

    assign adc_o        = adc_q;
    assign meas_o       = meas_q;
    assign meas_valid_o = meas_valid_q;

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        meas_valid_q |-> state_q == DET_EVAL)
        else $error("meas_valid outside DET_EVAL");

endmodule

// ==== rtl/fads_pkg.sv ====
package fads_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and timing
    //////////////////////////////////////////////////////////////////////

    localparam int ADC_W       = 14;
    localparam int MEAS_W      = 32;   // Counters, areas, times, bus data
    localparam int N_CH        = 2;
    localparam int SENSE_W     = $clog2(N_CH);
    localparam int CLS_W       = 16;
    localparam int CLKS_PER_US = 125;  // Prescaler terminal count, 126 cycles per tick
    localparam int PRESC_W     = $clog2(CLKS_PER_US + 1);
    localparam int ADDR_DEC_W  = 20;

    typedef logic [ADDR_DEC_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam reg_addr_t ADDR_SOFT_RESET    = 20'h00020;
    localparam reg_addr_t ADDR_SORT_DELAY    = 20'h00024;
    localparam reg_addr_t ADDR_SORT_DURATION = 20'h00028;
    localparam reg_addr_t ADDR_DROPLET_ID    = 20'h00200;
    localparam reg_addr_t ADDR_INTENSITY     = 20'h00204;  // Per channel, stride 4
    localparam reg_addr_t ADDR_WIDTH         = 20'h0021C;
    localparam reg_addr_t ADDR_AREA          = 20'h00234;
    localparam reg_addr_t ADDR_CLASS         = 20'h0024C;
    localparam reg_addr_t ADDR_TIME          = 20'h00250;
    localparam reg_addr_t ADDR_SENSE_CH      = 20'h00304;
    localparam reg_addr_t ADDR_ADC           = 20'h0030C;
    localparam reg_addr_t ADDR_INT_MIN       = 20'h01000;  // Thresholds, stride 4
    localparam reg_addr_t ADDR_INT_LOW       = 20'h01020;
    localparam reg_addr_t ADDR_INT_HIGH      = 20'h01040;
    localparam reg_addr_t ADDR_WID_MIN       = 20'h01060;
    localparam reg_addr_t ADDR_WID_LOW       = 20'h01080;
    localparam reg_addr_t ADDR_WID_HIGH      = 20'h010A0;
    localparam reg_addr_t ADDR_AREA_MIN      = 20'h010C0;

    // Class word bit positions
    localparam int CLS_INT_LOW  = 0;
    localparam int CLS_INT_POS  = 1;
    localparam int CLS_INT_HIGH = 2;
    localparam int CLS_WID_LOW  = 3;
    localparam int CLS_WID_POS  = 4;
    localparam int CLS_WID_HIGH = 5;
    localparam int CLS_SORTED   = 14;
    localparam int CLS_POSITIVE = 15;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [ADC_W-1:0] adc_sample_t;

    typedef struct packed {
        adc_sample_t              int_min;
        adc_sample_t              int_low;
        adc_sample_t              int_high;
        logic [MEAS_W-1:0]        wid_min;
        logic [MEAS_W-1:0]        wid_low;
        logic [MEAS_W-1:0]        wid_high;
        logic signed [MEAS_W-1:0] area_min;
    } chan_thr_t;

    typedef struct packed {
        chan_thr_t [N_CH-1:0] thr;
        logic [MEAS_W-1:0]    sort_delay;     // In microseconds
        logic [MEAS_W-1:0]    sort_duration;
        logic [SENSE_W-1:0]   sense_ch;
        logic                 soft_reset;
    } fads_cfg_t;

    typedef struct packed {
        adc_sample_t              peak;
        logic [MEAS_W-1:0]        width;
        logic signed [MEAS_W-1:0] area;
    } chan_meas_t;

    typedef struct packed {
        chan_meas_t [N_CH-1:0] ch;
    } droplet_meas_t;

    typedef struct packed {
        logic [MEAS_W-1:0] id;
        droplet_meas_t     meas;
        logic [CLS_W-1:0]  cls;
        logic [MEAS_W-1:0] time_us;
    } droplet_result_t;

    typedef struct packed {
        logic [MEAS_W-1:0] addr;
        logic [MEAS_W-1:0] wdata;
        logic              wen;
        logic              ren;
    } sys_req_t;

    typedef struct packed {
        logic [MEAS_W-1:0] rdata;
        logic              ack;
    } sys_rsp_t;

    typedef enum logic [1:0] {DET_IDLE, DET_WAIT, DET_ACQUIRE, DET_EVAL} det_state_e;
    typedef enum logic [1:0] {SORT_IDLE, SORT_DELAY, SORT_PULSE} sort_state_e;

    // Reset defaults
    localparam chan_thr_t THR_DEFAULT = '{
        int_min:  -14'sd175,
        int_low:  -14'sd150,
        int_high: 14'sd900,
        wid_min:  32'd1250,     // 10 us at 125 MHz
        wid_low:  32'd12500,
        wid_high: 32'hCCDD_EEFF,
        area_min: 32'sd1
    };
    localparam logic [MEAS_W-1:0]  SORT_DELAY_DEF    = 32'd100;
    localparam logic [MEAS_W-1:0]  SORT_DURATION_DEF = 32'd50;
    localparam logic [SENSE_W-1:0] SENSE_CH_DEF      = '0;
    localparam adc_sample_t        SIGNAL_MAX_INIT   = {1'b1, {(ADC_W-1){1'b0}}};

    // Address of channel c in a stride-4 block
    function automatic reg_addr_t ch_addr(reg_addr_t base, int c);
        return base + ADDR_DEC_W'(4 * c);
    endfunction

endpackage

// ==== rtl/fads_regs.sv ====
`timescale 1ns/100ps

module fads_regs (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  fads_pkg::sys_req_t                         sys_req_i,
    output fads_pkg::sys_rsp_t                         sys_rsp_o,
    output fads_pkg::fads_cfg_t                        cfg_o,
    input  fads_pkg::droplet_result_t                  result_i,
    input  fads_pkg::adc_sample_t [fads_pkg::N_CH-1:0] adc_i
);
    import fads_pkg::*;

    fads_cfg_t         cfg_q;
    reg_addr_t         addr;
    logic [MEAS_W-1:0] wdata;
    logic [MEAS_W-1:0] rd_word;
    logic [MEAS_W-1:0] rdata_q;
    logic              ack_q;

    assign addr  = sys_req_i.addr[ADDR_DEC_W-1:0];   // Upper bits ignored
    assign wdata = sys_req_i.wdata;

    function automatic logic [MEAS_W-1:0] zext_adc(adc_sample_t v);
        return {{(MEAS_W-ADC_W){1'b0}}, v};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Configuration registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < N_CH; c++) begin
                cfg_q.thr[c] <= THR_DEFAULT;
            end
            cfg_q.sort_delay    <= SORT_DELAY_DEF;
            cfg_q.sort_duration <= SORT_DURATION_DEF;
            cfg_q.sense_ch      <= SENSE_CH_DEF;
            cfg_q.soft_reset    <= 1'b0;
        end else if (sys_req_i.wen) begin
            case (addr)
                ADDR_SOFT_RESET:    cfg_q.soft_reset    <= wdata[0];
                ADDR_SORT_DELAY:    cfg_q.sort_delay    <= wdata;
                ADDR_SORT_DURATION: cfg_q.sort_duration <= wdata;
                ADDR_SENSE_CH:      cfg_q.sense_ch      <= wdata[SENSE_W-1:0];
                default: ;
            endcase
            for (int c = 0; c < N_CH; c++) begin
                if (addr == ch_addr(ADDR_INT_MIN, c))  cfg_q.thr[c].int_min  <= wdata[ADC_W-1:0];
                if (addr == ch_addr(ADDR_INT_LOW, c))  cfg_q.thr[c].int_low  <= wdata[ADC_W-1:0];
                if (addr == ch_addr(ADDR_INT_HIGH, c)) cfg_q.thr[c].int_high <= wdata[ADC_W-1:0];
                if (addr == ch_addr(ADDR_WID_MIN, c))  cfg_q.thr[c].wid_min  <= wdata;
                if (addr == ch_addr(ADDR_WID_LOW, c))  cfg_q.thr[c].wid_low  <= wdata;
                if (addr == ch_addr(ADDR_WID_HIGH, c)) cfg_q.thr[c].wid_high <= wdata;
                if (addr == ch_addr(ADDR_AREA_MIN, c)) cfg_q.thr[c].area_min <= wdata;
            end
        end
    end

    assign cfg_o = cfg_q;

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////

    // Unmapped addresses fall through as zero
    always_comb begin
        rd_word = '0;
        case (addr)
            ADDR_SOFT_RESET:    rd_word = MEAS_W'(cfg_q.soft_reset);
            ADDR_SORT_DELAY:    rd_word = cfg_q.sort_delay;
            ADDR_SORT_DURATION: rd_word = cfg_q.sort_duration;
            ADDR_SENSE_CH:      rd_word = MEAS_W'(cfg_q.sense_ch);
            ADDR_DROPLET_ID:    rd_word = result_i.id;
            ADDR_CLASS:         rd_word = MEAS_W'(result_i.cls);
            ADDR_TIME:          rd_word = result_i.time_us;
            default: ;
        endcase
        for (int c = 0; c < N_CH; c++) begin
            if (addr == ch_addr(ADDR_INT_MIN, c))   rd_word = zext_adc(cfg_q.thr[c].int_min);
            if (addr == ch_addr(ADDR_INT_LOW, c))   rd_word = zext_adc(cfg_q.thr[c].int_low);
            if (addr == ch_addr(ADDR_INT_HIGH, c))  rd_word = zext_adc(cfg_q.thr[c].int_high);
            if (addr == ch_addr(ADDR_WID_MIN, c))   rd_word = cfg_q.thr[c].wid_min;
            if (addr == ch_addr(ADDR_WID_LOW, c))   rd_word = cfg_q.thr[c].wid_low;
            if (addr == ch_addr(ADDR_WID_HIGH, c))  rd_word = cfg_q.thr[c].wid_high;
            if (addr == ch_addr(ADDR_AREA_MIN, c))  rd_word = cfg_q.thr[c].area_min;
            if (addr == ch_addr(ADDR_INTENSITY, c)) rd_word = zext_adc(result_i.meas.ch[c].peak);
            if (addr == ch_addr(ADDR_WIDTH, c))     rd_word = result_i.meas.ch[c].width;
            if (addr == ch_addr(ADDR_AREA, c))      rd_word = result_i.meas.ch[c].area;
            if (addr == ch_addr(ADDR_ADC, c))       rd_word = zext_adc(adc_i[c]);
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= rd_word;
        if (!rstn_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sys_req_i.wen || sys_req_i.ren;   // Every address is acked
        end
    end

    assign sys_rsp_o.rdata = rdata_q;
    assign sys_rsp_o.ack   = ack_q;

    // One ack per strobe, exactly one cycle later
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        sys_rsp_o.ack == $past(sys_req_i.wen || sys_req_i.ren))
        else $error("bus ack out of step with strobe");

endmodule

// ==== rtl/fads_top.sv ====
`timescale 1ns/100ps

module fads_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  fads_pkg::adc_sample_t adc_a_i,
    input  fads_pkg::adc_sample_t adc_b_i,
    input  fads_pkg::sys_req_t    sys_req_i,
    output fads_pkg::sys_rsp_t    sys_rsp_o,
    output logic                  sort_pulse_o
);
    import fads_pkg::*;

    fads_cfg_t              cfg;
    droplet_result_t        result;
    adc_sample_t [N_CH-1:0] adc_q;
    droplet_meas_t          meas;
    logic                   meas_valid;
    logic [MEAS_W-1:0]      now_us;
    logic                   sort_req;
    logic                   sort_busy;

    fads_regs u_regs (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .sys_req_i (sys_req_i),
        .sys_rsp_o (sys_rsp_o),
        .cfg_o     (cfg),
        .result_i  (result),
        .adc_i     (adc_q)
    );

    fads_us_timer u_timer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .soft_reset_i (cfg.soft_reset),
        .now_us_o     (now_us)
    );

    droplet_detector u_detector (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .adc_a_i      (adc_a_i),
        .adc_b_i      (adc_b_i),
        .cfg_i        (cfg),
        .adc_o        (adc_q),
        .meas_o       (meas),
        .meas_valid_o (meas_valid)
    );

    droplet_classifier u_classifier (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cfg_i        (cfg),
        .meas_i       (meas),
        .meas_valid_i (meas_valid),
        .now_us_i     (now_us),
        .sort_busy_i  (sort_busy),
        .result_o     (result),
        .sort_req_o   (sort_req)
    );

    sort_scheduler u_sorter (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cfg_i        (cfg),
        .now_us_i     (now_us),
        .sort_req_i   (sort_req),
        .sort_busy_o  (sort_busy),
        .sort_pulse_o (sort_pulse_o)
    );

endmodule

// ==== rtl/fads_us_timer.sv ====
`timescale 1ns/100ps

module fads_us_timer (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        soft_reset_i,
    output logic [fads_pkg::MEAS_W-1:0] now_us_o
);
    import fads_pkg::*;

    logic [PRESC_W-1:0] presc_q;
    logic [MEAS_W-1:0]  now_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i || soft_reset_i) begin
            presc_q <= '0;
            now_q   <= '0;
        end else if (presc_q == PRESC_W'(CLKS_PER_US)) begin
            presc_q <= '0;
            now_q   <= now_q + MEAS_W'(1);   // One microsecond elapsed
        end else begin
            presc_q <= presc_q + PRESC_W'(1);
        end
    end

    assign now_us_o = now_q;

endmodule

// ==== rtl/sort_scheduler.sv ====
`timescale 1ns/100ps

module sort_scheduler (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fads_pkg::fads_cfg_t         cfg_i,
    input  logic [fads_pkg::MEAS_W-1:0] now_us_i,
    input  logic                        sort_req_i,
    output logic                        sort_busy_o,
    output logic                        sort_pulse_o
);
    import fads_pkg::*;

    sort_state_e       state_q;
    logic [MEAS_W-1:0] end_us_q;   // Delay end, then pulse end
    logic              pulse_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i || cfg_i.soft_reset) begin
            state_q <= SORT_IDLE;
            pulse_q <= 1'b0;
        end else begin
            case (state_q)
                SORT_IDLE: begin
                    pulse_q <= 1'b0;
                    if (sort_req_i) begin
                        end_us_q <= now_us_i + cfg_i.sort_delay;
                        state_q  <= SORT_DELAY;
                    end
                end
                SORT_DELAY: begin
                    if (now_us_i >= end_us_q) begin
                        end_us_q <= now_us_i + cfg_i.sort_duration;
                        state_q  <= SORT_PULSE;
                    end
                end
                SORT_PULSE: begin
                    if (now_us_i < end_us_q) begin
                        pulse_q <= 1'b1;
                    end else begin
                        pulse_q <= 1'b0;   // Falling edge ends the sort
                        state_q <= SORT_IDLE;
                    end
                end
                default: state_q <= SORT_IDLE;
            endcase
        end
    end

    assign sort_busy_o  = state_q != SORT_IDLE;
    assign sort_pulse_o = pulse_q;

    // Classifier must hold off requests while a sort is pending
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        sort_req_i |-> !sort_busy_o)
        else $error("sort request while scheduler busy");

endmodule

// ==== sim/fads_tb.sv ====
`timescale 1ns/100ps

module fads_tb;
    import fads_pkg::*;

    localparam int TICK           = CLKS_PER_US + 1;   // Cycles per microsecond
    localparam int N_DROPLETS     = 5;
    localparam int N_SORTS        = 3;
    localparam int MAX_WIDTH      = 60;
    localparam int LONG_DURATION  = 3;                 // Long sort pulse in microseconds
    localparam int DROPLET_CYCLES = MAX_WIDTH + 100;   // Pulse, gap and readback
    localparam int SORT_CYCLES    = (1 + LONG_DURATION + 2) * TICK;
    localparam int TIMEOUT_CYCLES = 2 * (400 + N_DROPLETS * DROPLET_CYCLES
                                         + N_SORTS * SORT_CYCLES + 3 * TICK);
    localparam int IDLE_LEVEL     = 0;                 // Below every working int_min
    localparam int WID_MIN_SENSE  = 10;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    adc_sample_t adc_a_i;
    adc_sample_t adc_b_i;
    sys_req_t    req;
    sys_rsp_t    rsp;
    logic        sort_pulse;
    logic [31:0] rng_state = 32'h5c5c_3280;
    int          cycle_cnt = 0;
    logic        quiet_window = 1'b0;   // Sort pulse must stay low
    logic [31:0] last_id = '0;

    fads_top dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .adc_a_i      (adc_a_i),
        .adc_b_i      (adc_b_i),
        .sys_req_i    (req),
        .sys_rsp_o    (rsp),
        .sort_pulse_o (sort_pulse)
    );

    always #2 clk_i = ~clk_i;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, run still going after %0d cycles", cycle_cnt));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req.wen || req.ren) |=> rsp.ack)
        else abort_run("Bus ack missing one cycle after a strobe");
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req.wen || req.ren) |=> !rsp.ack)
        else abort_run("Bus ack seen without a strobe");
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        quiet_window |-> !sort_pulse)
        else abort_run("Sort pulse raised after a negative droplet");

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                                 name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int rand_range(int lo, int hi);
        rng_state = xorshift32(rng_state);
        return lo + int'(rng_state % 32'(hi - lo + 1));
    endfunction

    function automatic reg_addr_t chan_addr(reg_addr_t base, int c);
        return base + ADDR_DEC_W'(4 * c);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus and droplet stimulus entered just after a clock edge
    //////////////////////////////////////////////////////////////////////

    task automatic bus_write(reg_addr_t addr, logic [31:0] data);
        req.addr  = 32'(addr);
        req.wdata = data;
        req.wen   = 1'b1;
        @(posedge clk_i);
        #1;
        req.wen = 1'b0;
        check_value("sys_rsp_o.ack", 32'(rsp.ack), 32'd1);
    endtask

    task automatic expect_reg(string name, reg_addr_t addr, logic [31:0] exp);
        req.addr = 32'(addr);
        req.ren  = 1'b1;
        @(posedge clk_i);
        #1;
        req.ren = 1'b0;
        check_value("sys_rsp_o.ack", 32'(rsp.ack), 32'd1);
        check_value(name, rsp.rdata, exp);
    endtask

    task automatic send_droplet(int n, int level);
        adc_a_i = ADC_W'(level);
        adc_b_i = ADC_W'(level);
        repeat (n) @(posedge clk_i);
        #1;
        adc_a_i = ADC_W'(IDLE_LEVEL);
        adc_b_i = ADC_W'(IDLE_LEVEL);
        repeat (3) @(posedge clk_i);   // Capture, DET_EVAL, result register
        #1;
    endtask

    // Width n on sense channel 0 and peak and area of both channels from the level
    task automatic check_droplet(int n, int level, logic [15:0] cls);
        last_id = last_id + 32'd1;
        expect_reg("droplet_id", ADDR_DROPLET_ID, last_id);
        expect_reg("width[0]", chan_addr(ADDR_WIDTH, 0), 32'(n));
        expect_reg("width[1]", chan_addr(ADDR_WIDTH, 1), 32'd0);
        for (int c = 0; c < N_CH; c++) begin
            expect_reg($sformatf("intensity[%0d]", c), chan_addr(ADDR_INTENSITY, c),
                       32'(level) & 32'h0000_3FFF);
            expect_reg($sformatf("area[%0d]", c), chan_addr(ADDR_AREA, c), 32'(n * level));
        end
        expect_reg("class", ADDR_CLASS, {16'h0000, cls});
    endtask

    task automatic measure_sort_pulse(int max_wait, output int high_cycles);
        int waited;
        waited      = 0;
        high_cycles = 0;
        while (!sort_pulse) begin
            if (waited >= max_wait) abort_run("Sort pulse never rose");
            @(posedge clk_i);
            #1;
            waited++;
        end
        while (sort_pulse) begin
            if (high_cycles >= max_wait) abort_run("Sort pulse never fell");
            @(posedge clk_i);
            #1;
            high_cycles++;
        end
    endtask

    task automatic check_pulse_len(int high, int duration);
        assert (high >= (duration - 1) * TICK && high <= (duration + 1) * TICK)
        else abort_run($sformatf(
            "CHECK FAILED sort_pulse_o high cycles: got 0x%0h, expected 0x%0h..0x%0h",
            high, (duration - 1) * TICK, (duration + 1) * TICK));
    endtask

    task automatic program_thresholds();
        for (int c = 0; c < N_CH; c++) begin
            bus_write(chan_addr(ADDR_INT_MIN, c), 32'd100);
            bus_write(chan_addr(ADDR_INT_LOW, c), 32'd150);
            bus_write(chan_addr(ADDR_INT_HIGH, c), 32'd1000);
            // Channel 1 never counts width, so its width band starts at zero
            bus_write(chan_addr(ADDR_WID_MIN, c), (c == 0) ? 32'(WID_MIN_SENSE) : 32'd0);
            bus_write(chan_addr(ADDR_WID_LOW, c), (c == 0) ? 32'd15 : 32'd0);
            bus_write(chan_addr(ADDR_WID_HIGH, c), 32'd100);
            bus_write(chan_addr(ADDR_AREA_MIN, c), 32'd1);
        end
    endtask

    initial begin
        reg_addr_t   thr_base [7];
        reg_addr_t   chk_addr [$];
        logic [31:0] chk_val [$];
        logic [31:0] v;
        int          n;
        int          level;
        int          high;

        thr_base = '{ADDR_INT_MIN, ADDR_INT_LOW, ADDR_INT_HIGH, ADDR_WID_MIN,
                     ADDR_WID_LOW, ADDR_WID_HIGH, ADDR_AREA_MIN};
        rstn_i  = 1'b0;
        adc_a_i = ADC_W'(IDLE_LEVEL);
        adc_b_i = ADC_W'(IDLE_LEVEL);
        req     = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Register readback with the datapath parked in soft reset
        bus_write(ADDR_SOFT_RESET, 32'd1);
        foreach (thr_base[i]) begin
            for (int c = 0; c < N_CH; c++) begin
                v = xorshift32(rng_state);
                rng_state = v;
                bus_write(chan_addr(thr_base[i], c), v);
                chk_addr.push_back(chan_addr(thr_base[i], c));
                chk_val.push_back((i < 3) ? (v & 32'h0000_3FFF) : v);   // 14-bit intensities
            end
        end
        v = xorshift32(rng_state);
        bus_write(ADDR_SORT_DELAY, v);
        chk_addr.push_back(ADDR_SORT_DELAY);
        chk_val.push_back(v);
        v = xorshift32(v);
        rng_state = v;
        bus_write(ADDR_SORT_DURATION, v);
        chk_addr.push_back(ADDR_SORT_DURATION);
        chk_val.push_back(v);
        foreach (chk_addr[i]) begin
            expect_reg($sformatf("reg[0x%05h]", chk_addr[i]), chk_addr[i], chk_val[i]);
        end
        expect_reg("unmapped", 20'h00400, 32'd0);
        expect_reg("unmapped", 20'h010C8, 32'd0);

        program_thresholds();
        bus_write(ADDR_SORT_DELAY, 32'd1);
        bus_write(ADDR_SORT_DURATION, 32'd1);
        bus_write(ADDR_SENSE_CH, 32'd0);
        bus_write(ADDR_SOFT_RESET, 32'd0);

        // Positive droplet, then its sort pulse
        n     = rand_range(20, MAX_WIDTH);
        level = rand_range(200, 800);
        send_droplet(n, level);
        check_droplet(n, level, 16'hC012);
        measure_sort_pulse(SORT_CYCLES, high);
        check_pulse_len(high, 1);

        // Noise narrower than the width minimum
        send_droplet(rand_range(2, WID_MIN_SENSE - 2), rand_range(200, 800));
        expect_reg("droplet_id", ADDR_DROPLET_ID, last_id);

        // Negative droplet above int_high
        n     = rand_range(20, MAX_WIDTH);
        level = rand_range(1500, 4000);
        send_droplet(n, level);
        check_droplet(n, level, 16'h0014);
        quiet_window = 1'b1;
        repeat (3 * TICK) @(posedge clk_i);
        #1;
        quiet_window = 1'b0;

        // Longer sort pulse
        bus_write(ADDR_SORT_DURATION, 32'(LONG_DURATION));
        n     = rand_range(20, MAX_WIDTH);
        level = rand_range(200, 800);
        send_droplet(n, level);
        check_droplet(n, level, 16'hC012);
        measure_sort_pulse(SORT_CYCLES, high);
        check_pulse_len(high, LONG_DURATION);

        // Soft reset clears ID and time
        bus_write(ADDR_SOFT_RESET, 32'd1);
        bus_write(ADDR_SOFT_RESET, 32'd0);
        expect_reg("droplet_id", ADDR_DROPLET_ID, 32'd0);
        expect_reg("time", ADDR_TIME, 32'd0);
        last_id = '0;
        n     = rand_range(20, MAX_WIDTH);
        level = rand_range(200, 800);
        send_droplet(n, level);
        check_droplet(n, level, 16'hC012);

        $display("Everything OK");
        $finish;
    end

endmodule
